// ==== list.f ====
+incdir+.
l3_pkg.sv
l3_step_if.sv
l3_ctrl.sv
l3_weight_store.sv
l3_conv_relu.sv
l3_fc_accum.sv
l3_top.sv
l3_props.sv
l3_tb.sv

// ==== l3_tb.sv ====
`include "l3_config.svh"

module l3_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ACK_LIMIT    = 50;    // Cycles allowed for any handshake edge
    localparam int SIG_LOAD_ACK = 0;
    localparam int SIG_PIX_ACK  = 1;
    localparam int SIG_READY    = 2;

    logic               o_clk;
    logic               rst_n;
    logic               i_load_req;
    l3_pkg::data_t      i_load_data;
    logic               o_load_ack;
    logic               i_pix_req;
    l3_pkg::pix_vec_t   i_pix;
    logic               o_pix_ack;
    logic               o_ready;
    logic               o_valid;
    l3_pkg::score_vec_t o_scores;

    logic [31:0]        rng;
    l3_pkg::data_t      words [`L3_LOAD_WORDS];      // Load stream, also the model's parameters
    int                 exp_score [`L3_NUM_CLASS];
    int                 value_errs;
    int                 proto_errs;

    l3_top dut0 (.*);

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lcg_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'((lcg_next() >> 8) % (hi - lo + 1));
    endfunction

    function automatic logic probe(input int which);
        case (which)
            SIG_LOAD_ACK: return o_load_ack;
            SIG_PIX_ACK:  return o_pix_ack;
            default:      return o_ready;
        endcase
    endfunction

    task automatic finish_run();
        proto_errs += dut0.u_props.fail_cnt;          // Failed bound properties
        $display("Value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic wait_for(input int which, input logic level, input string what);
        int n;
        n = 0;
        while (probe(which) !== level) begin
            @(posedge o_clk);
            n++;
            if (n > ACK_LIMIT) begin
                proto_errs++;
                $display("Timeout: %s never went to %0b", what, level);
                finish_run();
            end
        end
    endtask

    task automatic load_word(input l3_pkg::data_t w);
        assert (o_ready == 1'b0) else begin
            proto_errs++;
            $display("o_ready rose before all parameter words were loaded");
        end
        i_load_req  <= 1'b1;
        i_load_data <= w;
        wait_for(SIG_LOAD_ACK, 1'b1, "o_load_ack");
        i_load_req <= 1'b0;
        wait_for(SIG_LOAD_ACK, 1'b0, "o_load_ack");
    endtask

    task automatic send_pix(input l3_pkg::pix_vec_t px, input int hold);
        i_pix_req <= 1'b1;
        i_pix     <= px;
        wait_for(SIG_PIX_ACK, 1'b1, "o_pix_ack");
        repeat (hold) begin                                // Host back-pressure
            @(posedge o_clk);
            assert (o_pix_ack == 1'b1) else begin
                proto_errs++;
                $display("o_pix_ack dropped while i_pix_req was still high");
            end
        end
        i_pix_req <= 1'b0;
        wait_for(SIG_PIX_ACK, 1'b0, "o_pix_ack");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model updated one position at a time
    //////////////////////////////////////////////////////////////////////
    task automatic model_position(input int p, input l3_pkg::pix_vec_t px);
        int sum;
        int relu [`L3_NUM_MAP];
        int base;
        for (int m = 0; m < `L3_NUM_MAP; m++) begin
            sum = int'(words[m * (`L3_NUM_CH + 1) + `L3_NUM_CH]);   // Filter bias
            for (int c = 0; c < `L3_NUM_CH; c++) begin
                sum += int'(words[m * (`L3_NUM_CH + 1) + c]) * int'(px[c]);
            end
            if (sum < 0) begin
                relu[m] = 0;
            end else if (sum > `L3_RELU_MAX) begin
                relu[m] = `L3_RELU_MAX;
            end else begin
                relu[m] = sum;
            end
        end
        for (int k = 0; k < `L3_NUM_CLASS; k++) begin
            base = `L3_CONV_WORDS + k * `L3_CLASS_WORDS;
            if (p == 0) begin
                exp_score[k] = int'(words[base + `L3_NUM_MAP * `L3_NUM_POS]);
            end
            for (int m = 0; m < `L3_NUM_MAP; m++) begin
                exp_score[k] += relu[m] * int'(words[base + m * `L3_NUM_POS + p]);
            end
        end
    endtask

    // Mode 0 sends small random pixels and mode 1 alternating full scale positions
    task automatic run_frame(input int mode);
        l3_pkg::pix_vec_t px;
        logic             was_valid;
        was_valid = o_valid;
        for (int p = 0; p < `L3_NUM_POS; p++) begin
            for (int c = 0; c < `L3_NUM_CH; c++) begin
                if (mode == 0) begin
                    px[c] = l3_pkg::data_t'(rand_range(-8, 7));
                end else if (p % 2 == 0) begin
                    px[c] = 8'sd127;
                end else begin
                    px[c] = -8'sd128;
                end
            end
            model_position(p, px);
            repeat (rand_range(0, 2)) @(posedge o_clk);   // Idle gap
            send_pix(px, rand_range(0, 3));
            if (p == 0 && was_valid) begin
                assert (o_valid == 1'b0) else begin
                    value_errs++;
                    $display("[ERROR] o_valid got %h expected %h", o_valid, 1'b0);
                end
            end
        end
        assert (o_valid == 1'b1) else begin
            value_errs++;
            $display("[ERROR] o_valid got %h expected %h", o_valid, 1'b1);
        end
        for (int k = 0; k < `L3_NUM_CLASS; k++) begin
            assert (o_scores[k] == l3_pkg::acc_t'(exp_score[k])) else begin
                value_errs++;
                $display("[ERROR] o_scores[%0d] got %h expected %h", k, o_scores[k],
                         exp_score[k]);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        rng         = 32'd96863;
        value_errs  = 0;
        proto_errs  = 0;
        rst_n       = 1'b0;
        i_load_req  = 1'b0;
        i_load_data = '0;
        i_pix_req   = 1'b0;
        i_pix       = '0;
        repeat (8) @(posedge o_clk);
        rst_n <= 1'b1;
        @(posedge o_clk);
        assert (!o_ready && !o_valid && !o_load_ack && !o_pix_ack) else begin
            value_errs++;
            $display("[ERROR] o_ready/o_valid/o_load_ack/o_pix_ack got %h expected %h",
                     {o_ready, o_valid, o_load_ack, o_pix_ack}, 4'h0);
        end

        i_pix_req <= 1'b1;                                 // Too early so it must be ignored
        repeat (ACK_LIMIT) begin
            @(posedge o_clk);
            assert (o_pix_ack == 1'b0) else begin
                proto_errs++;
                $display("Pixel request was acked before the parameters were loaded");
            end
        end
        i_pix_req <= 1'b0;
        @(posedge o_clk);

        for (int i = 0; i < `L3_LOAD_WORDS; i++) begin
            if (i < `L3_NUM_CH) begin
                words[i] = l3_pkg::data_t'(rand_range(1, 15));      // Filter 0 all positive
            end else if (i > `L3_NUM_CH && i < 2 * `L3_NUM_CH + 1) begin
                words[i] = l3_pkg::data_t'(rand_range(-16, -1));    // Filter 1 all negative
            end else begin
                words[i] = l3_pkg::data_t'(rand_range(-128, 127));
            end
        end
        for (int i = 0; i < `L3_LOAD_WORDS; i++) begin
            load_word(words[i]);
        end
        wait_for(SIG_READY, 1'b1, "o_ready");

        i_load_req <= 1'b1;                                // Late load that is never acked
        repeat (10) begin
            @(posedge o_clk);
            assert (o_load_ack == 1'b0) else begin
                proto_errs++;
                $display("Load request was acked after loading had completed");
            end
        end
        i_load_req <= 1'b0;
        @(posedge o_clk);

        for (int f = 0; f < 3; f++) begin
            run_frame(0);
        end
        run_frame(1);
        run_frame(0);
        finish_run();
    end

endmodule

// ==== l3_props.sv ====
module l3_props (
    input logic               o_clk,
    input logic               rst_n,
    input logic               i_load_req,
    input logic               o_load_ack,
    input logic               i_pix_req,
    input logic               o_pix_ack,
    input logic               o_ready,
    input logic               o_valid,
    input l3_pkg::score_vec_t o_scores
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;                                  // Summed into the final report

    // Acks answer a request seen on the previous edge
    a_load_ack_req: assert property (@(posedge o_clk) disable iff (!rst_n)
        $rose(o_load_ack) |-> $past(i_load_req))
        else begin
            fail_cnt++;
            $error("o_load_ack rose without i_load_req");
        end

    a_pix_ack_req: assert property (@(posedge o_clk) disable iff (!rst_n)
        $rose(o_pix_ack) |-> $past(i_pix_req))
        else begin
            fail_cnt++;
            $error("o_pix_ack rose without i_pix_req");
        end

    // CONV and ACCUM take one cycle each
    a_pix_latency: assert property (@(posedge o_clk) disable iff (!rst_n)
        $rose(i_pix_req) && o_ready |-> ##3 $rose(o_pix_ack))
        else begin
            fail_cnt++;
            $error("o_pix_ack did not rise three cycles after i_pix_req");
        end

    a_no_late_load: assert property (@(posedge o_clk) disable iff (!rst_n)
        o_ready |-> !o_load_ack)
        else begin
            fail_cnt++;
            $error("o_load_ack high after loading completed");
        end

    a_scores_held: assert property (@(posedge o_clk) disable iff (!rst_n)
        o_valid && $past(o_valid) |-> $stable(o_scores))
        else begin
            fail_cnt++;
            $error("o_scores changed while o_valid was high");
        end

endmodule

bind l3_top l3_props u_props (.*);

// ==== l3_top.sv ====
module l3_top (
    input  logic               o_clk,
    input  logic               rst_n,

    // Parameter load port
    input  logic               i_load_req,
    input  l3_pkg::data_t      i_load_data,
    output logic               o_load_ack,

    // Pixel port
    input  logic               i_pix_req,
    input  l3_pkg::pix_vec_t   i_pix,
    output logic               o_pix_ack,

    output logic               o_ready,
    output logic               o_valid,
    output l3_pkg::score_vec_t o_scores
);

    l3_step_if         step_bus ();
    l3_wt_if           wt_bus ();
    l3_pkg::relu_vec_t relu;                 // Conv stage to FC stage

    l3_ctrl u_ctrl (
        .o_clk      (o_clk),
        .rst_n      (rst_n),
        .i_load_req (i_load_req),
        .i_pix_req  (i_pix_req),
        .o_load_ack (o_load_ack),
        .o_pix_ack  (o_pix_ack),
        .o_ready    (o_ready),
        .o_valid    (o_valid),
        .step       (step_bus.ctrl)
    );

    l3_weight_store u_store (
        .o_clk       (o_clk),
        .rst_n       (rst_n),
        .i_load_data (i_load_data),
        .step        (step_bus.dp),
        .wt          (wt_bus.store)
    );

    l3_conv_relu u_conv (
        .o_clk  (o_clk),
        .rst_n  (rst_n),
        .i_pix  (i_pix),
        .step   (step_bus.dp),
        .wt     (wt_bus.user),
        .o_relu (relu)
    );

    l3_fc_accum u_fc (
        .o_clk    (o_clk),
        .rst_n    (rst_n),
        .i_relu   (relu),
        .step     (step_bus.dp),
        .wt       (wt_bus.user),
        .o_scores (o_scores)
    );

endmodule

// ==== l3_fc_accum.sv ====
`include "l3_config.svh"

module l3_fc_accum (
    input  logic               o_clk,
    input  logic               rst_n,
    input  l3_pkg::relu_vec_t  i_relu,
    l3_step_if.dp              step,
    l3_wt_if.user              wt,
    output l3_pkg::score_vec_t o_scores
);

    l3_pkg::score_vec_t score_d;

    // Next score per class
    always_comb begin
        for (int k = 0; k < `L3_NUM_CLASS; k++) begin
            if (step.frame_first) begin
                score_d[k] = l3_pkg::acc_t'($signed(wt.fc_b[k]));   // Bias preload
            end else begin
                score_d[k] = o_scores[k];
            end
            for (int m = 0; m < `L3_NUM_MAP; m++) begin
                score_d[k] = score_d[k]
                           + l3_pkg::acc_t'(i_relu[m])            // ReLU output is unsigned
                           * l3_pkg::acc_t'($signed(wt.fc_w[k][m]));
            end
        end
    end

    always_ff @(posedge o_clk or negedge rst_n) begin
        if (!rst_n) begin
            o_scores <= '0;
        end else if (step.acc_en) begin
            o_scores <= score_d;
        end
    end

endmodule

// ==== l3_conv_relu.sv ====
`include "l3_config.svh"

module l3_conv_relu (
    input  logic              o_clk,
    input  logic              rst_n,
    input  l3_pkg::pix_vec_t  i_pix,
    l3_step_if.dp             step,
    l3_wt_if.user             wt,
    output l3_pkg::relu_vec_t o_relu
);

    localparam int RELU_W = $bits(l3_pkg::relu_vec_t) / `L3_NUM_MAP;

    l3_pkg::acc_t      conv_sum [`L3_NUM_MAP];
    l3_pkg::relu_vec_t relu_d;

    // 1x1 convolution per filter then clamp to 0..RELU_MAX
    always_comb begin
        for (int m = 0; m < `L3_NUM_MAP; m++) begin
            conv_sum[m] = l3_pkg::acc_t'($signed(wt.conv_b[m]));
            for (int c = 0; c < `L3_NUM_CH; c++) begin
                conv_sum[m] = conv_sum[m]
                            + l3_pkg::acc_t'($signed(wt.conv_w[m][c]))
                            * l3_pkg::acc_t'($signed(i_pix[c]));
            end
            if (conv_sum[m] < 0) begin
                relu_d[m] = '0;
            end else if (conv_sum[m] > `L3_RELU_MAX) begin
                relu_d[m] = RELU_W'(`L3_RELU_MAX);            // Saturate
            end else begin
                relu_d[m] = conv_sum[m][RELU_W-1:0];
            end
        end
    end

    always_ff @(posedge o_clk or negedge rst_n) begin
        if (!rst_n) begin
            o_relu <= '0;
        end else if (step.conv_en) begin
            o_relu <= relu_d;                                  // Held through ACCUM
        end
    end

endmodule

// ==== l3_weight_store.sv ====
`include "l3_config.svh"

module l3_weight_store (
    input  logic          o_clk,
    input  logic          rst_n,
    input  l3_pkg::data_t i_load_data,
    l3_step_if.dp         step,
    l3_wt_if.store        wt
);

    localparam int CONV_SPAN    = `L3_NUM_CH + 1;          // Weights plus bias per filter
    localparam int CH_W         = $clog2(CONV_SPAN);
    localparam int MAP_W        = $clog2(`L3_NUM_MAP);
    localparam int CLASS_W      = $clog2(`L3_NUM_CLASS);
    localparam int REM_W        = $clog2(`L3_CLASS_WORDS);
    localparam int FC_BIAS_SLOT = `L3_NUM_MAP * `L3_NUM_POS; // Last word of a class

    l3_pkg::data_t [`L3_NUM_MAP-1:0][`L3_NUM_CH-1:0] conv_w_q;
    l3_pkg::data_t [`L3_NUM_MAP-1:0]                 conv_b_q;
    l3_pkg::data_t [`L3_NUM_CLASS-1:0][`L3_NUM_MAP-1:0][`L3_NUM_POS-1:0] fc_w_q;
    l3_pkg::data_t [`L3_NUM_CLASS-1:0]               fc_b_q;

    logic               is_conv;
    logic [MAP_W-1:0]   conv_map;
    logic [CH_W-1:0]    conv_idx;
    l3_pkg::load_addr_t fc_off;
    logic [CLASS_W-1:0] fc_class;
    logic [REM_W-1:0]   fc_rem;
    logic [MAP_W-1:0]   fc_map;
    l3_pkg::pos_t       fc_pos;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        is_conv  = (step.load_addr < l3_pkg::load_addr_t'(`L3_CONV_WORDS));
        conv_map = MAP_W'(step.load_addr / CONV_SPAN);
        conv_idx = CH_W'(step.load_addr % CONV_SPAN);
        fc_off   = step.load_addr - l3_pkg::load_addr_t'(`L3_CONV_WORDS);
        fc_class = CLASS_W'(fc_off / `L3_CLASS_WORDS);
        fc_rem   = REM_W'(fc_off % `L3_CLASS_WORDS);
        fc_map   = MAP_W'(fc_rem / `L3_NUM_POS);
        fc_pos   = l3_pkg::pos_t'(fc_rem % `L3_NUM_POS);
    end

    always_ff @(posedge o_clk or negedge rst_n) begin
        if (!rst_n) begin
            conv_w_q <= '0;
            conv_b_q <= '0;
            fc_w_q   <= '0;
            fc_b_q   <= '0;
        end else if (step.load_wr) begin
            if (is_conv) begin
                if (conv_idx == CH_W'(`L3_NUM_CH)) begin
                    conv_b_q[conv_map] <= i_load_data;
                end else begin
                    conv_w_q[conv_map][conv_idx] <= i_load_data;
                end
            end else if (fc_rem == REM_W'(FC_BIAS_SLOT)) begin
                fc_b_q[fc_class] <= i_load_data;
            end else begin
                fc_w_q[fc_class][fc_map][fc_pos] <= i_load_data;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////////////////////////
    assign wt.conv_w = conv_w_q;
    assign wt.conv_b = conv_b_q;
    assign wt.fc_b   = fc_b_q;

    always_comb begin
        for (int k = 0; k < `L3_NUM_CLASS; k++) begin
            for (int m = 0; m < `L3_NUM_MAP; m++) begin
                wt.fc_w[k][m] = fc_w_q[k][m][step.pos];   // Select current position
            end
        end
    end

endmodule

// ==== l3_ctrl.sv ====
`include "l3_config.svh"

module l3_ctrl (
    input  logic       o_clk,
    input  logic       rst_n,
    input  logic       i_load_req,
    input  logic       i_pix_req,
    output logic       o_load_ack,
    output logic       o_pix_ack,
    output logic       o_ready,
    output logic       o_valid,
    l3_step_if.ctrl    step
);

    l3_pkg::ctrl_state_e state;
    l3_pkg::load_addr_t  load_cnt;   // Word being loaded
    l3_pkg::pos_t        pos_cnt;    // Position being processed
    logic                load_wr_q;
    logic                load_last;
    logic                pos_last;

    assign load_last = (load_cnt == l3_pkg::load_addr_t'(`L3_LOAD_WORDS - 1));
    assign pos_last  = (pos_cnt == l3_pkg::pos_t'(`L3_NUM_POS - 1));

    //////////////////////////////////////////////////////////////////////
    // Handshake FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge o_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= l3_pkg::RESET_IDLE;
            load_cnt   <= '0;
            pos_cnt    <= '0;
            load_wr_q  <= 1'b0;
            o_load_ack <= 1'b0;
            o_pix_ack  <= 1'b0;
            o_ready    <= 1'b0;
            o_valid    <= 1'b0;
        end else begin
            load_wr_q <= 1'b0;                      // Single cycle write strobe
            case (state)
                l3_pkg::RESET_IDLE: begin
                    state <= l3_pkg::LOAD_WAIT;
                end
                l3_pkg::LOAD_WAIT: begin
                    if (i_load_req) begin
                        load_wr_q  <= 1'b1;
                        o_load_ack <= 1'b1;
                        state      <= l3_pkg::LOAD_ACK;
                    end
                end
                l3_pkg::LOAD_ACK: begin
                    if (!i_load_req) begin
                        o_load_ack <= 1'b0;
                        if (load_last) begin
                            o_ready <= 1'b1;        // Held until reset
                            state   <= l3_pkg::PIX_WAIT;
                        end else begin
                            load_cnt <= load_cnt + 1'b1;
                            state    <= l3_pkg::LOAD_WAIT;
                        end
                    end
                end
                l3_pkg::PIX_WAIT: begin
                    if (i_pix_req) begin
                        if (pos_cnt == '0) begin
                            o_valid <= 1'b0;        // New frame drops old scores
                        end
                        state <= l3_pkg::CONV;
                    end
                end
                l3_pkg::CONV: begin
                    state <= l3_pkg::ACCUM;
                end
                l3_pkg::ACCUM: begin
                    o_pix_ack <= 1'b1;
                    if (pos_last) begin
                        o_valid <= 1'b1;            // Scores complete with last ack
                    end
                    state <= l3_pkg::PIX_ACK;
                end
                l3_pkg::PIX_ACK: begin
                    if (!i_pix_req) begin
                        o_pix_ack <= 1'b0;
                        pos_cnt   <= pos_last ? '0 : pos_cnt + 1'b1;
                        state     <= l3_pkg::PIX_WAIT;
                    end
                end
                default: begin
                    state <= l3_pkg::RESET_IDLE;
                end
            endcase
        end
    end

    assign step.load_wr     = load_wr_q;
    assign step.load_addr   = load_cnt;
    assign step.pos         = pos_cnt;
    assign step.frame_first = (pos_cnt == '0);
    assign step.conv_en     = (state == l3_pkg::CONV);
    assign step.acc_en      = (state == l3_pkg::ACCUM);

endmodule

// ==== l3_step_if.sv ====
`include "l3_config.svh"

// Strobes and indices from control to the datapath
interface l3_step_if;
    logic               load_wr;     // One word written from the load port
    l3_pkg::load_addr_t load_addr;
    l3_pkg::pos_t       pos;
    logic               frame_first; // Position 0 of a frame
    logic               conv_en;
    logic               acc_en;

    modport ctrl (output load_wr, load_addr, pos, frame_first, conv_en, acc_en);
    modport dp   (input  load_wr, load_addr, pos, frame_first, conv_en, acc_en);
endinterface

// Parameter set presented by the weight store
interface l3_wt_if;
    l3_pkg::data_t [`L3_NUM_MAP-1:0][`L3_NUM_CH-1:0]   conv_w;
    l3_pkg::data_t [`L3_NUM_MAP-1:0]                   conv_b;
    l3_pkg::data_t [`L3_NUM_CLASS-1:0][`L3_NUM_MAP-1:0] fc_w;   // Current position only
    l3_pkg::data_t [`L3_NUM_CLASS-1:0]                 fc_b;

    modport store (output conv_w, conv_b, fc_w, fc_b);
    modport user  (input  conv_w, conv_b, fc_w, fc_b);
endinterface

// ==== l3_pkg.sv ====
`include "l3_config.svh"

package l3_pkg;

    typedef enum logic [2:0] {
        RESET_IDLE,                  // First cycle out of reset
        LOAD_WAIT,
        LOAD_ACK,
        PIX_WAIT,                    // Weights loaded, waiting for a position
        CONV,
        ACCUM,
        PIX_ACK
    } ctrl_state_e;

    typedef logic signed [`L3_DATA_W-1:0] data_t;
    typedef data_t [`L3_NUM_CH-1:0]       pix_vec_t;          // One position, all channels
    typedef logic [`L3_NUM_MAP-1:0][$clog2(`L3_RELU_MAX+1)-1:0] relu_vec_t;
    typedef logic signed [`L3_ACC_W-1:0]  acc_t;
    typedef acc_t [`L3_NUM_CLASS-1:0]     score_vec_t;

    typedef logic [$clog2(`L3_LOAD_WORDS)-1:0] load_addr_t;   // Load word index
    typedef logic [$clog2(`L3_NUM_POS)-1:0]    pos_t;         // Position index

endpackage

// ==== l3_config.svh ====
`ifndef L3_CONFIG_SVH
`define L3_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////
`define L3_DATA_W      8         // Pixels and weights
`define L3_ACC_W       32        // Accumulators and scores

//////////////////////////////////////////////////////////////////////
// Layer geometry
//////////////////////////////////////////////////////////////////////
`define L3_NUM_CH      12        // Input channels per position
`define L3_NUM_MAP     2         // 1x1 filters
`define L3_NUM_POS     36        // 6x6 feature map
`define L3_NUM_CLASS   10
`define L3_RELU_MAX    127       // Upper clamp of ReLU

// Load stream holds 2x(12+1) conv words then 10x(2x36+1) class words
`define L3_CONV_WORDS  26
`define L3_CLASS_WORDS 73
`define L3_LOAD_WORDS  756

`endif
